// ==== logic/bt_rx_sync_macros.svh ====
`ifndef BT_RX_SYNC_MACROS_SVH
`define BT_RX_SYNC_MACROS_SVH

// sync word and sliding window length
`define SYNC_WORD_W 64

// mismatch count for 0 to 64
`define MISMATCH_W 7

`define THRESH_W 6

// clk_6M cycles per received bit
`define TICK_DIV 6

`define HIT_COUNT_W 16

`endif

// ==== logic/bt_rx_sync_pkg.sv ====
`include "bt_rx_sync_macros.svh"

package bt_rx_sync_pkg;

  typedef enum logic [1:0] {
    idle,
    page_scan,
    inquiry_scan,
    connection
  } link_mode_e;

  typedef enum logic [1:0] {
    cac,
    dac,
    giac,
    diac
  } access_code_e;

  typedef struct packed {
    logic [`SYNC_WORD_W-1:0] cac;
    logic [`SYNC_WORD_W-1:0] dac;
    logic [`SYNC_WORD_W-1:0] giac;
    logic [`SYNC_WORD_W-1:0] diac;
  } access_codes_t;

  typedef struct packed {
    link_mode_e           mode;
    logic                 use_diac;
    logic [`THRESH_W-1:0] threshold;
  } sync_cfg_t;

  typedef struct packed {
    logic                   valid;
    access_code_e           code;
    logic [`MISMATCH_W-1:0] mismatches;
  } corr_result_t;

  typedef struct packed {
    access_code_e           code;
    logic [`MISMATCH_W-1:0] mismatches;
  } sync_event_t;

endpackage

// ==== logic/bit_tick_gen.sv ====
`timescale 1ns/1ps
`include "bt_rx_sync_macros.svh"

module bit_tick_gen (
  input  logic clk_6M,
  input  logic rstz,
  output logic p_1us
);

  localparam int CNT_W = $clog2(`TICK_DIV);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`TICK_DIV - 1);

  logic [CNT_W-1:0] tick_cnt;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      tick_cnt <= '0;
    else if (tick_cnt == LAST_CNT)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  // strobe on the last count of each bit period
  assign p_1us = (tick_cnt == LAST_CNT);

  a_tick_one_wide: assert property (@(posedge clk_6M) disable iff (!rstz)
    p_1us |=> !p_1us)
    else $error("p_1us high in two consecutive cycles");

endmodule

// ==== logic/rx_bit_sampler.sv ====
`timescale 1ns/1ps

module rx_bit_sampler (
  input  logic clk_6M,
  input  logic rstz,
  input  logic p_1us,
  input  logic rxbit,
  output logic bit_valid,
  output logic bit_value
);

  // two-flop resync of the asynchronous serial input
  logic [1:0] rxbit_sync;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rxbit_sync <= 2'b00;
    else
      rxbit_sync <= {rxbit_sync[0], rxbit};
  end

  // capture once per bit
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bit_value <= 1'b0;
    else if (p_1us)
      bit_value <= rxbit_sync[1];
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bit_valid <= 1'b0;
    else
      bit_valid <= p_1us;
  end

  a_valid_after_tick: assert property (@(posedge clk_6M) disable iff (!rstz)
    p_1us |=> bit_valid)
    else $error("bit_valid missing one cycle after p_1us");

endmodule

// ==== logic/sync_correlator.sv ====
`timescale 1ns/1ps
`include "bt_rx_sync_macros.svh"

module sync_correlator (
  input  logic                          clk_6M,
  input  logic                          rstz,
  input  logic                          bit_valid,
  input  logic                          bit_value,
  input  bt_rx_sync_pkg::access_codes_t codes,
  input  bt_rx_sync_pkg::link_mode_e    mode,
  input  logic                          use_diac,
  output bt_rx_sync_pkg::corr_result_t  corr
);

  logic [`SYNC_WORD_W-1:0]      syncin_word;
  logic [`SYNC_WORD_W-1:0]      next_word;
  logic [`SYNC_WORD_W-1:0]      code_word;
  logic [`SYNC_WORD_W-1:0]      diff_word;
  logic [`MISMATCH_W-1:0]       mismatch_cnt;
  logic                         code_en;
  bt_rx_sync_pkg::access_code_e code_sel;

  logic                         corr_valid;
  bt_rx_sync_pkg::access_code_e corr_code;
  logic [`MISMATCH_W-1:0]       corr_mismatches;

  // newest bit enters at bit 0
  assign next_word = {syncin_word[`SYNC_WORD_W-2:0], bit_value};

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      syncin_word <= '0;
    else if (bit_valid)
      syncin_word <= next_word;
  end

  // access code by link state
  always_comb
  begin
    code_en   = 1'b1;
    code_sel  = bt_rx_sync_pkg::cac;
    code_word = codes.cac;
    case (mode)
      bt_rx_sync_pkg::connection:
      begin
        code_sel  = bt_rx_sync_pkg::cac;
        code_word = codes.cac;
      end
      bt_rx_sync_pkg::page_scan:
      begin
        code_sel  = bt_rx_sync_pkg::dac;
        code_word = codes.dac;
      end
      bt_rx_sync_pkg::inquiry_scan:
      begin
        code_sel  = use_diac ? bt_rx_sync_pkg::diac : bt_rx_sync_pkg::giac;
        code_word = use_diac ? codes.diac : codes.giac;
      end
      default:
        code_en = 1'b0;
    endcase
  end

  assign diff_word = next_word ^ code_word;

  // population count of differing bits
  always_comb
  begin
    mismatch_cnt = '0;
    for (int i = 0; i < `SYNC_WORD_W; i++)
    begin
      mismatch_cnt = mismatch_cnt + `MISMATCH_W'(diff_word[i]);
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      corr_valid <= 1'b0;
    else
      corr_valid <= bit_valid && code_en;
  end

  always_ff @(posedge clk_6M)
  begin
    if (bit_valid)
    begin
      corr_code       <= code_sel;
      corr_mismatches <= mismatch_cnt;
    end
  end

  assign corr = '{valid: corr_valid, code: corr_code, mismatches: corr_mismatches};

endmodule

// ==== logic/sync_report.sv ====
`timescale 1ns/1ps
`include "bt_rx_sync_macros.svh"

module sync_report (
  input  logic                         clk_6M,
  input  logic                         rstz,
  input  bt_rx_sync_pkg::corr_result_t corr,
  input  logic [`THRESH_W-1:0]         threshold,
  output logic                         sync_hit,
  output bt_rx_sync_pkg::sync_event_t  sync_event,
  output logic [`HIT_COUNT_W-1:0]      hit_count
);

  logic hit;

  // at most threshold mismatches counts as a hit
  assign hit = corr.valid &&
               (corr.mismatches <= `MISMATCH_W'(threshold));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sync_hit <= 1'b0;
    else
      sync_hit <= hit;
  end

  always_ff @(posedge clk_6M)
  begin
    if (hit)
    begin
      sync_event.code       <= corr.code;
      sync_event.mismatches <= corr.mismatches;
    end
  end

  // saturating hit counter
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hit_count <= '0;
    else if (hit && (hit_count != '1))
      hit_count <= hit_count + 1'b1;
  end

  // bits are six cycles apart, so two hits never touch
  a_hit_one_wide: assert property (@(posedge clk_6M) disable iff (!rstz)
    sync_hit |=> !sync_hit)
    else $error("sync_hit high in two consecutive cycles");

endmodule

// ==== logic/bt_rx_sync_top.sv ====
`timescale 1ns/1ps
`include "bt_rx_sync_macros.svh"

module bt_rx_sync_top (
  input  logic                          clk_6M,
  input  logic                          rstz,
  input  logic                          rxbit,
  input  bt_rx_sync_pkg::access_codes_t codes,
  input  bt_rx_sync_pkg::sync_cfg_t     cfg,
  output logic                          p_1us,
  output logic                          sync_hit,
  output bt_rx_sync_pkg::sync_event_t   sync_event,
  output logic [`HIT_COUNT_W-1:0]       hit_count
);

  logic                         bit_valid;
  logic                         bit_value;
  bt_rx_sync_pkg::corr_result_t corr;

  bit_tick_gen bit_tick_gen_u (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .p_1us  (p_1us)
  );

  rx_bit_sampler rx_bit_sampler_u (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .p_1us     (p_1us),
    .rxbit     (rxbit),
    .bit_valid (bit_valid),
    .bit_value (bit_value)
  );

  sync_correlator sync_correlator_u (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .bit_valid (bit_valid),
    .bit_value (bit_value),
    .codes     (codes),
    .mode      (cfg.mode),
    .use_diac  (cfg.use_diac),
    .corr      (corr)
  );

  sync_report sync_report_u (
    .clk_6M     (clk_6M),
    .rstz       (rstz),
    .corr       (corr),
    .threshold  (cfg.threshold),
    .sync_hit   (sync_hit),
    .sync_event (sync_event),
    .hit_count  (hit_count)
  );

endmodule

// ==== verification/sync_checker.sv ====
`timescale 1ns/1ps
`include "bt_rx_sync_macros.svh"

module sync_checker (
  input  logic                        clk_6M,
  input  logic                        rstz,
  input  logic                        p_1us,
  input  logic                        sync_hit,
  input  bt_rx_sync_pkg::sync_event_t sync_event,
  input  logic [`HIT_COUNT_W-1:0]     hit_count,
  input  logic                        exp_valid,
  input  logic                        exp_hit,
  input  bt_rx_sync_pkg::sync_event_t exp_event,
  input  logic [`HIT_COUNT_W-1:0]     exp_count,
  output int                          value_errors,
  output int                          strobe_errors
);

  // expectation is delayed two stages to line up with sync_hit
  logic                        pend1_valid;
  logic                        pend1_hit;
  bt_rx_sync_pkg::sync_event_t pend1_event;
  logic [`HIT_COUNT_W-1:0]     pend1_count;
  logic                        pend2_valid;
  logic                        pend2_hit;
  bt_rx_sync_pkg::sync_event_t pend2_event;
  logic [`HIT_COUNT_W-1:0]     pend2_count;
  int                          cyc;
  int                          n_value = 0;
  int                          n_strobe = 0;

  assign value_errors  = n_value;
  assign strobe_errors = n_strobe;

  always @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      pend1_valid <= 1'b0;
      pend2_valid <= 1'b0;
      cyc         <= 0;
    end
    else
    begin
      // tick spacing counted from reset release
      if (p_1us != ((cyc % `TICK_DIV) == (`TICK_DIV - 1)))
      begin
        $display("CHECK FAILED at %0t: p_1us = %0b, expected %0b", $time, p_1us, !p_1us);
        n_value++;
      end
      if (cyc < `TICK_DIV && hit_count != '0)
      begin
        $display("CHECK FAILED at %0t: hit_count = %0d, expected 0", $time, hit_count);
        n_value++;
      end
      if (pend2_valid)
      begin
        if (sync_hit != pend2_hit)
        begin
          if (pend2_hit)
            $display("missing sync_hit at %0t for a sampled bit", $time);
          else
            $display("unexpected sync_hit at %0t for a sampled bit", $time);
          n_strobe++;
        end
        else if (sync_hit)
        begin
          if (sync_event.code != pend2_event.code)
          begin
            $display("CHECK FAILED at %0t: sync_event.code = %0d, expected %0d",
                     $time, sync_event.code, pend2_event.code);
            n_value++;
          end
          if (sync_event.mismatches != pend2_event.mismatches)
          begin
            $display("CHECK FAILED at %0t: sync_event.mismatches = %0d, expected %0d",
                     $time, sync_event.mismatches, pend2_event.mismatches);
            n_value++;
          end
        end
        if (hit_count != pend2_count)
        begin
          $display("CHECK FAILED at %0t: hit_count = %0d, expected %0d",
                   $time, hit_count, pend2_count);
          n_value++;
        end
      end
      else if (sync_hit)
      begin
        $display("unexpected sync_hit at %0t with no bit sampled three cycles before", $time);
        n_strobe++;
      end
      pend2_valid <= pend1_valid;
      pend2_hit   <= pend1_hit;
      pend2_event <= pend1_event;
      pend2_count <= pend1_count;
      pend1_valid <= exp_valid;
      pend1_hit   <= exp_hit;
      pend1_event <= exp_event;
      pend1_count <= exp_count;
      cyc         <= cyc + 1;
    end
  end

endmodule

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps
`include "bt_rx_sync_macros.svh"

module tb_top;

  localparam int RUN_LIMIT  = 400000;
  localparam int TICK_LIMIT = 2 * `TICK_DIV;
  localparam int SEGMENTS   = 12;

  logic                          clk_6M;
  logic                          rstz;
  logic                          rxbit;
  bt_rx_sync_pkg::access_codes_t codes;
  bt_rx_sync_pkg::sync_cfg_t     cfg;
  logic                          p_1us;
  logic                          sync_hit;
  bt_rx_sync_pkg::sync_event_t   sync_event;
  logic [`HIT_COUNT_W-1:0]       hit_count;

  logic                          exp_valid;
  logic                          exp_hit;
  bt_rx_sync_pkg::sync_event_t   exp_event;
  logic [`HIT_COUNT_W-1:0]       exp_count;
  int                            value_errors;
  int                            strobe_errors;
  int                            timeouts = 0;
  logic                          stim_done = 1'b0;

  // reference model state
  logic [15:0]                   lfsr;
  bt_rx_sync_pkg::access_codes_t next_codes;
  bt_rx_sync_pkg::sync_cfg_t     next_cfg;
  logic [`SYNC_WORD_W-1:0]       model_window;
  logic [`HIT_COUNT_W-1:0]       model_hits;
  logic                          pending_bit;

  bt_rx_sync_top dut_i (
    .clk_6M     (clk_6M),
    .rstz       (rstz),
    .rxbit      (rxbit),
    .codes      (codes),
    .cfg        (cfg),
    .p_1us      (p_1us),
    .sync_hit   (sync_hit),
    .sync_event (sync_event),
    .hit_count  (hit_count)
  );

  sync_checker checker_i (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .p_1us         (p_1us),
    .sync_hit      (sync_hit),
    .sync_event    (sync_event),
    .hit_count     (hit_count),
    .exp_valid     (exp_valid),
    .exp_hit       (exp_hit),
    .exp_event     (exp_event),
    .exp_count     (exp_count),
    .value_errors  (value_errors),
    .strobe_errors (strobe_errors)
  );

  initial
  begin
    clk_6M = 1'b0;
    forever #2 clk_6M = ~clk_6M;
  end

  // fibonacci LFSR with taps 16 14 13 11
  function automatic logic [`SYNC_WORD_W-1:0] rand_bits(input int n);
    logic [`SYNC_WORD_W-1:0] r;
    logic                    fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[`SYNC_WORD_W-2:0], fb};
    end
    return r;
  endfunction

  function automatic int rand_int(input int n);
    return int'(rand_bits(n));
  endfunction

  function automatic logic [`SYNC_WORD_W-1:0] code_word(
    input bt_rx_sync_pkg::access_codes_t cs,
    input bt_rx_sync_pkg::access_code_e  id
  );
    case (id)
      bt_rx_sync_pkg::cac:  return cs.cac;
      bt_rx_sync_pkg::dac:  return cs.dac;
      bt_rx_sync_pkg::giac: return cs.giac;
      default:              return cs.diac;
    endcase
  endfunction

  // access code that the link state listens for
  function automatic bt_rx_sync_pkg::access_code_e mode_code(input bt_rx_sync_pkg::sync_cfg_t c);
    if (c.mode == bt_rx_sync_pkg::connection)
      return bt_rx_sync_pkg::cac;
    else if (c.mode == bt_rx_sync_pkg::page_scan)
      return bt_rx_sync_pkg::dac;
    else if (c.use_diac)
      return bt_rx_sync_pkg::diac;
    else
      return bt_rx_sync_pkg::giac;
  endfunction

  // drive one bit at the edge that ends a p_1us cycle
  task automatic send_bit(input logic b);
    int                     waited;
    logic [`MISMATCH_W-1:0] mism;
    logic                   hit;
    waited = 0;
    @(posedge clk_6M);
    while (!p_1us && waited < TICK_LIMIT)
    begin
      @(posedge clk_6M);
      waited++;
    end
    if (!p_1us)
    begin
      $display("timeout at %0t: no p_1us within %0d cycles", $time, TICK_LIMIT);
      timeouts++;
    end
    // this edge captures the bit driven one tick earlier
    model_window = {model_window[`SYNC_WORD_W-2:0], pending_bit};
    mism = `MISMATCH_W'($countones(model_window ^ code_word(next_codes, mode_code(next_cfg))));
    hit  = (next_cfg.mode != bt_rx_sync_pkg::idle) &&
           (mism <= `MISMATCH_W'(next_cfg.threshold));
    if (hit && model_hits != '1)
      model_hits = model_hits + 16'd1;
    exp_valid   <= 1'b1;
    exp_hit     <= hit;
    exp_event   <= '{code: mode_code(next_cfg), mismatches: mism};
    exp_count   <= model_hits;
    rxbit       <= b;
    cfg         <= next_cfg;
    codes       <= next_codes;
    pending_bit = b;
    @(posedge clk_6M);
    exp_valid <= 1'b0;
  endtask

  task automatic send_filler(input int n);
    for (int i = 0; i < n; i++)
    begin
      send_bit(1'(rand_int(1)));
    end
  endtask

  task automatic run_segment();
    logic [`SYNC_WORD_W-1:0]      word;
    logic [`SYNC_WORD_W-1:0]      flips;
    int                           nflip;
    int                           kind;
    int                           thr;
    int                           guard;
    bt_rx_sync_pkg::access_code_e id;
    next_codes.cac     = rand_bits(64);
    next_codes.dac     = rand_bits(64);
    next_codes.giac    = rand_bits(64);
    next_codes.diac    = rand_bits(64);
    next_cfg.mode      = bt_rx_sync_pkg::link_mode_e'(2'(rand_int(2)));
    next_cfg.use_diac  = 1'(rand_int(1));
    next_cfg.threshold = 6'(rand_int(4));
    thr = int'(next_cfg.threshold);
    send_filler(16 + rand_int(5));
    for (int c = 0; c < 3; c++)
    begin
      kind = rand_int(3);
      id   = mode_code(next_cfg);
      if (next_cfg.mode == bt_rx_sync_pkg::idle || kind == 7)
        id = bt_rx_sync_pkg::access_code_e'(2'(rand_int(2)));
      case (kind)
        2:       nflip = thr;
        3:       nflip = thr + 1;
        4, 5:    nflip = rand_int(4) % (thr + 1);
        6:       nflip = thr + 1 + rand_int(2);
        default: nflip = 0;
      endcase
      flips = '0;
      guard = 0;
      while ($countones(flips) < nflip && guard < 1000)
      begin
        flips[rand_int(6)] = 1'b1;
        guard++;
      end
      word = code_word(next_codes, id) ^ flips;
      // most significant bit first
      for (int i = `SYNC_WORD_W - 1; i >= 0; i--)
      begin
        send_bit(word[i]);
      end
      send_filler(4 + rand_int(4));
    end
  endtask

  // a code with a zero upper half matches only a cleared window
  task automatic send_short_code();
    next_cfg.mode      = bt_rx_sync_pkg::connection;
    next_cfg.threshold = '0;
    next_codes.cac     = rand_bits(32);
    for (int i = 31; i >= 0; i--)
    begin
      send_bit(next_codes.cac[i]);
    end
    send_bit(1'b0);
  endtask

  // mid-run reset once the last hit slot has passed
  task automatic apply_reset();
    repeat (3) @(posedge clk_6M);
    rstz  <= 1'b0;
    rxbit <= 1'b0;
    repeat (5) @(posedge clk_6M);
    rstz <= 1'b1;
    model_window = '0;
    model_hits   = '0;
    pending_bit  = 1'b0;
  endtask

  initial
  begin
    rstz         = 1'b0;
    rxbit        = 1'b0;
    codes        = '0;
    cfg          = '0;
    next_codes   = '0;
    next_cfg     = '0;
    exp_valid    = 1'b0;
    exp_hit      = 1'b0;
    exp_event    = '0;
    exp_count    = '0;
    lfsr         = 16'd30;
    model_window = '0;
    model_hits   = '0;
    pending_bit  = 1'b0;
    repeat (5) @(posedge clk_6M);
    rstz <= 1'b1;
    for (int s = 0; s < SEGMENTS; s++)
    begin
      if (s == SEGMENTS / 2)
      begin
        apply_reset();
        send_short_code();
      end
      run_segment();
    end
    repeat (4) @(posedge clk_6M);
    stim_done = 1'b1;
  end

  initial
  begin : watchdog
    int   cycles;
    logic late;
    cycles = 0;
    late   = 1'b0;
    while (!stim_done && cycles < RUN_LIMIT)
    begin
      @(posedge clk_6M);
      cycles++;
    end
    if (!stim_done)
    begin
      $display("timeout: stimulus not finished after %0d cycles", RUN_LIMIT);
      late = 1'b1;
    end
    $display("errors: %0d value, %0d strobe, %0d timeout", value_errors, strobe_errors,
             timeouts + int'(late));
    if (value_errors == 0 && strobe_errors == 0 && timeouts == 0 && !late)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== bt_rx_sync.f ====
+incdir+logic
logic/bt_rx_sync_pkg.sv
logic/bit_tick_gen.sv
logic/rx_bit_sampler.sv
logic/sync_correlator.sv
logic/sync_report.sv
logic/bt_rx_sync_top.sv
verification/sync_checker.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sync detector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_top \
  -f bt_rx_sync.f -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict comes from the log
if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
